// File: hdl/cu_config.svh
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

//////////////////////////////////////////////////
// Memory line geometry
//////////////////////////////////////////////////

// Width of one cache line in bits
`define CU_LINE_BITS 512

// Bytes per graph element written
`define CU_ELEM_BYTES 4

// Byte address width on the memory side
`define CU_ADDR_BITS 64

//////////////////////////////////////////////////
// Write path sizing
//////////////////////////////////////////////////

// Entries in the command/data buffer
`define CU_BUF_DEPTH 4

// Write credits granted after reset
`define CU_CREDITS 2

`endif

// File: hdl/mem_cmd_pkg.sv
`default_nettype none

package mem_cmd_pkg;

	//////////////////////////////////////////////////
	// Write command fields
	//////////////////////////////////////////////////

	// Write kind sent with each command
	typedef enum logic [1:0] {
		WRITE_NA = 2'd0,
		WRITE_MS = 2'd1
	} cmd_kind_t;

	// Abort behaviour of the memory command
	typedef enum logic [2:0] {
		STRICT = 3'd0,
		ABORT  = 3'd1,
		PAGE   = 3'd2,
		SPEC   = 3'd3,
		PREF   = 3'd4
	} abort_mode_t;

	// Tag carried by each issued command
	typedef logic [7:0] cmd_tag_t;

	// Word position inside a cache line
	typedef logic [3:0] line_slot_t;

	// Config field to abort mode, unknown codes fall back to STRICT
	function automatic abort_mode_t map_abort(input logic [2:0] code);
		abort_mode_t mode;
		case (code)
			3'd1: mode = ABORT;
			3'd2: mode = PAGE;
			3'd3: mode = SPEC;
			3'd4: mode = PREF;
			default: mode = STRICT;
		endcase
		return mode;
	endfunction

endpackage

`default_nettype wire

// File: hdl/edge_data_pkg.sv
`default_nettype none

`include "cu_config.svh"

package edge_data_pkg;

	//////////////////////////////////////////////////
	// Edge data layout
	//////////////////////////////////////////////////

	// Element and line geometry in words
	localparam int ELEM_BITS  = `CU_ELEM_BYTES * 8;
	localparam int LINE_WORDS = `CU_LINE_BITS / ELEM_BITS;

	// Id of the compute unit behind a request
	typedef logic [7:0] cu_id_t;

	// One line, flat toward memory or split in element words
	typedef union packed {
		logic [`CU_LINE_BITS-1:0]               flat;
		logic [LINE_WORDS-1:0][ELEM_BITS-1:0]   words;
	} data_line_t;

	// Reverse byte order of one element
	function automatic logic [ELEM_BITS-1:0] swap_elem(input logic [ELEM_BITS-1:0] d);
		logic [ELEM_BITS-1:0] r;
		for (int b = 0; b < `CU_ELEM_BYTES; b++) begin
			r[b*8 +: 8] = d[(`CU_ELEM_BYTES-1-b)*8 +: 8];
		end
		return r;
	endfunction

endpackage

`default_nettype wire

// File: hdl/edge_data_write_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "cu_config.svh"

module edge_data_write_control
	import mem_cmd_pkg::*, edge_data_pkg::*;
(
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     enable,
	input  logic [63:0]              cfg_word,
	input  logic [`CU_ADDR_BITS-1:0] base_address,
	input  logic                     wr_strobe,
	input  logic [31:0]              wr_index,
	input  logic [31:0]              wr_data,
	input  cu_id_t                   wr_cu_id,
	output logic                     push,
	output cmd_kind_t                cmd_kind,
	output abort_mode_t              abort,
	output logic [`CU_ADDR_BITS-1:0] address,
	output line_slot_t               slot,
	output cu_id_t                   cu_id,
	output data_line_t               line
);

	localparam int ADDR_W = `CU_ADDR_BITS;
	localparam int SLOT_W = $bits(line_slot_t);

	logic                     enabled;
	logic [63:0]              cfg_latched;

	// First stage, the decoded request
	logic                     s1_valid;
	cmd_kind_t                s1_kind;
	abort_mode_t              s1_abort;
	logic [`CU_ADDR_BITS-1:0] s1_address;
	line_slot_t               s1_slot;
	cu_id_t                   s1_cu_id;
	data_line_t               s1_line;

	line_slot_t               req_slot;
	data_line_t               req_line;

	//////////////////////////////////////////////////
	// Enable and configuration
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled     <= 1'b0;
			cfg_latched <= '0;
		end else begin
			enabled <= enable;
			// Zero word keeps the old settings
			if (enabled && (|cfg_word))
				cfg_latched <= cfg_word;
		end
	end

	//////////////////////////////////////////////////
	// Line build
	//////////////////////////////////////////////////

	assign req_slot = wr_index[SLOT_W-1:0];

	always_comb begin
		req_line.flat            = '0;
		// Single element per line, swapped into its slot
		req_line.words[req_slot] = swap_elem(wr_data);
	end

	//////////////////////////////////////////////////
	// Request stage
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			s1_valid <= 1'b0;
		else
			s1_valid <= wr_strobe && enabled;
	end

	always_ff @(posedge clock) begin
		if (wr_strobe && enabled) begin
			s1_kind    <= cfg_latched[19] ? WRITE_MS : WRITE_NA;
			s1_abort   <= map_abort(cfg_latched[17:15]);
			// Index scaled to a byte offset
			s1_address <= base_address + (ADDR_W'(wr_index) << $clog2(`CU_ELEM_BYTES));
			s1_slot    <= req_slot;
			s1_cu_id   <= wr_cu_id;
			s1_line    <= req_line;
		end
	end

	//////////////////////////////////////////////////
	// Output stage toward the buffer
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			push <= 1'b0;
		else
			push <= s1_valid;
	end

	always_ff @(posedge clock) begin
		if (s1_valid) begin
			cmd_kind <= s1_kind;
			abort    <= s1_abort;
			address  <= s1_address;
			slot     <= s1_slot;
			cu_id    <= s1_cu_id;
			line     <= s1_line;
		end
	end

endmodule

`default_nettype wire

// File: hdl/write_command_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "cu_config.svh"

module write_command_buffer
	import mem_cmd_pkg::*, edge_data_pkg::*;
(
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     push,
	input  cmd_kind_t                cmd_kind,
	input  abort_mode_t              abort,
	input  logic [`CU_ADDR_BITS-1:0] address,
	input  line_slot_t               slot,
	input  cu_id_t                   cu_id,
	input  data_line_t               line,
	input  logic                     pop,
	output logic                     full,
	output logic                     empty,
	output cmd_kind_t                head_kind,
	output abort_mode_t              head_abort,
	output logic [`CU_ADDR_BITS-1:0] head_address,
	output line_slot_t               head_slot,
	output cu_id_t                   head_cu_id,
	output data_line_t               head_line
);

	localparam int DEPTH = `CU_BUF_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Entry storage
	cmd_kind_t                mem_kind    [DEPTH];
	abort_mode_t              mem_abort   [DEPTH];
	logic [`CU_ADDR_BITS-1:0] mem_address [DEPTH];
	line_slot_t               mem_slot    [DEPTH];
	cu_id_t                   mem_cu_id   [DEPTH];
	data_line_t               mem_line    [DEPTH];

	logic [PTR_W-1:0]         wr_ptr;
	logic [PTR_W-1:0]         rd_ptr;
	logic [CNT_W-1:0]         count;

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leave count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	//////////////////////////////////////////////////
	// Storage write and head read
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (push) begin
			mem_kind[wr_ptr]    <= cmd_kind;
			mem_abort[wr_ptr]   <= abort;
			mem_address[wr_ptr] <= address;
			mem_slot[wr_ptr]    <= slot;
			mem_cu_id[wr_ptr]   <= cu_id;
			mem_line[wr_ptr]    <= line;
		end
	end

	assign head_kind    = mem_kind[rd_ptr];
	assign head_abort   = mem_abort[rd_ptr];
	assign head_address = mem_address[rd_ptr];
	assign head_slot    = mem_slot[rd_ptr];
	assign head_cu_id   = mem_cu_id[rd_ptr];
	assign head_line    = mem_line[rd_ptr];

	// Overflow and underflow guards
	a_no_push_full: assert property (
		@(posedge clock) disable iff (!rstn) push |-> !full
	) else $error("push into full buffer");

	a_no_pop_empty: assert property (
		@(posedge clock) disable iff (!rstn) pop |-> !empty
	) else $error("pop from empty buffer");

endmodule

`default_nettype wire

// File: hdl/write_issue_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "cu_config.svh"

module write_issue_engine
	import mem_cmd_pkg::*, edge_data_pkg::*;
(
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     empty,
	input  cmd_kind_t                head_kind,
	input  abort_mode_t              head_abort,
	input  logic [`CU_ADDR_BITS-1:0] head_address,
	input  line_slot_t               head_slot,
	input  cu_id_t                   head_cu_id,
	input  data_line_t               head_line,
	input  logic                     credit_return,
	output logic                     pop,
	output logic                     mem_valid,
	output cmd_kind_t                mem_kind,
	output abort_mode_t              mem_abort,
	output logic [`CU_ADDR_BITS-1:0] mem_address,
	output cmd_tag_t                 mem_tag,
	output line_slot_t               mem_slot,
	output cu_id_t                   mem_cu_id,
	output logic [`CU_LINE_BITS-1:0] mem_line
);

	localparam int CRD_W = $clog2(`CU_CREDITS + 1);

	logic [CRD_W-1:0] credits;
	cmd_tag_t         next_tag;

	//////////////////////////////////////////////////
	// Issue decision
	//////////////////////////////////////////////////

	// Head leaves as soon as a credit is free
	assign pop = (credits != '0) && !empty;

	//////////////////////////////////////////////////
	// Credit and tag counters
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits  <= CRD_W'(`CU_CREDITS);
			next_tag <= '0;
		end else begin
			// Spend on issue, refill on return
			case ({pop, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			if (pop)
				next_tag <= next_tag + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Registered memory command
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			mem_valid <= 1'b0;
		else
			mem_valid <= pop;
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			mem_kind    <= head_kind;
			mem_abort   <= head_abort;
			mem_address <= head_address;
			mem_tag     <= next_tag;
			mem_slot    <= head_slot;
			mem_cu_id   <= head_cu_id;
			// Flat view toward memory
			mem_line    <= head_line.flat;
		end
	end

	// More returns than issues would push this over
	a_credit_bound: assert property (
		@(posedge clock) disable iff (!rstn) credits <= CRD_W'(`CU_CREDITS)
	) else $error("credit count above limit");

endmodule

`default_nettype wire

// File: hdl/edge_write_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cu_config.svh"

module edge_write_top
	import mem_cmd_pkg::*, edge_data_pkg::*;
(
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     enable,
	input  logic [63:0]              cfg_word,
	input  logic [`CU_ADDR_BITS-1:0] base_address,
	input  logic                     wr_strobe,
	input  logic [31:0]              wr_index,
	input  logic [31:0]              wr_data,
	input  cu_id_t                   wr_cu_id,
	input  logic                     credit_return,
	output logic                     buf_full,
	output logic                     mem_valid,
	output cmd_kind_t                mem_kind,
	output abort_mode_t              mem_abort,
	output logic [`CU_ADDR_BITS-1:0] mem_address,
	output cmd_tag_t                 mem_tag,
	output line_slot_t               mem_slot,
	output cu_id_t                   mem_cu_id,
	output logic [`CU_LINE_BITS-1:0] mem_line
);

	// Producer to buffer
	logic                     push;
	cmd_kind_t                cmd_kind;
	abort_mode_t              abort;
	logic [`CU_ADDR_BITS-1:0] address;
	line_slot_t               slot;
	cu_id_t                   cu_id;
	data_line_t               line;

	// Buffer to consumer
	logic                     pop;
	logic                     empty;
	cmd_kind_t                head_kind;
	abort_mode_t              head_abort;
	logic [`CU_ADDR_BITS-1:0] head_address;
	line_slot_t               head_slot;
	cu_id_t                   head_cu_id;
	data_line_t               head_line;

	//////////////////////////////////////////////////
	// Write path
	//////////////////////////////////////////////////

	edge_data_write_control ctrl_i (
		.clock(clock), .rstn(rstn), .enable(enable), .cfg_word(cfg_word),
		.base_address(base_address), .wr_strobe(wr_strobe), .wr_index(wr_index),
		.wr_data(wr_data), .wr_cu_id(wr_cu_id), .push(push), .cmd_kind(cmd_kind),
		.abort(abort), .address(address), .slot(slot), .cu_id(cu_id), .line(line)
	);

	write_command_buffer buf_i (
		.clock(clock), .rstn(rstn), .push(push), .cmd_kind(cmd_kind), .abort(abort),
		.address(address), .slot(slot), .cu_id(cu_id), .line(line), .pop(pop),
		.full(buf_full), .empty(empty), .head_kind(head_kind), .head_abort(head_abort),
		.head_address(head_address), .head_slot(head_slot), .head_cu_id(head_cu_id),
		.head_line(head_line)
	);

	write_issue_engine issue_i (
		.clock(clock), .rstn(rstn), .empty(empty), .head_kind(head_kind),
		.head_abort(head_abort), .head_address(head_address), .head_slot(head_slot),
		.head_cu_id(head_cu_id), .head_line(head_line), .credit_return(credit_return),
		.pop(pop), .mem_valid(mem_valid), .mem_kind(mem_kind), .mem_abort(mem_abort),
		.mem_address(mem_address), .mem_tag(mem_tag), .mem_slot(mem_slot),
		.mem_cu_id(mem_cu_id), .mem_line(mem_line)
	);

	// Requester holds off while the buffer is full
	a_no_strobe_full: assert property (
		@(posedge clock) disable iff (!rstn) wr_strobe |-> !buf_full
	) else $error("write strobe while buffer full");

endmodule

`default_nettype wire

// File: sim/edge_write_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cu_config.svh"

module edge_write_tb
	import mem_cmd_pkg::*, edge_data_pkg::*;
();

	localparam int NROWS   = 11;
	localparam int TIMEOUT = 20;

	// What a row does with its credit
	localparam logic [1:0] RETURN_CREDIT = 2'd0;
	localparam logic [1:0] KEEP_CREDIT   = 2'd1;
	localparam logic [1:0] QUEUE_ONLY    = 2'd2;

	logic                     clock;
	logic                     rstn;
	logic                     enable;
	logic [63:0]              cfg_word;
	logic [`CU_ADDR_BITS-1:0] base_address;
	logic                     wr_strobe;
	logic [31:0]              wr_index;
	logic [31:0]              wr_data;
	cu_id_t                   wr_cu_id;
	logic                     credit_return;
	logic                     buf_full;
	logic                     mem_valid;
	cmd_kind_t                mem_kind;
	abort_mode_t              mem_abort;
	logic [`CU_ADDR_BITS-1:0] mem_address;
	cmd_tag_t                 mem_tag;
	line_slot_t               mem_slot;
	cu_id_t                   mem_cu_id;
	logic [`CU_LINE_BITS-1:0] mem_line;

	//////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////

	// Bit 19 kind, bits 17..15 abort code, zero keeps the last word
	logic [63:0] tab_cfg [NROWS] = '{
		64'h0000_0000_0009_0000, 64'h0,                  64'hA5A5_0000_0001_8000,
		64'h0000_0000_000B_8000, 64'h0000_0000_0002_0000, 64'h0000_0000_0008_8000,
		64'h0,                  64'h0000_0000_0012_C000, 64'h0,
		64'h0000_0000_0009_8000, 64'h0
	};
	logic [31:0] tab_index [NROWS] = '{
		32'd5, 32'd19, 32'd256, 32'hFFFF_FFFF, 32'd42, 32'd7,
		32'd8, 32'd9, 32'd10, 32'd1000, 32'd33
	};
	logic [31:0] tab_data [NROWS] = '{
		32'h1122_3344, 32'h0, 32'h0, 32'hDEAD_BEEF, 32'h0, 32'h0,
		32'h0, 32'h0, 32'h0, 32'h0, 32'h0
	};
	// Data taken from the LCG instead
	logic tab_rand [NROWS] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
	cu_id_t tab_cu [NROWS] = '{
		8'h01, 8'h22, 8'h7F, 8'hFF, 8'h10, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08
	};
	logic [1:0] tab_mode [NROWS] = '{
		RETURN_CREDIT, RETURN_CREDIT, RETURN_CREDIT, RETURN_CREDIT, RETURN_CREDIT,
		KEEP_CREDIT, KEEP_CREDIT, QUEUE_ONLY, QUEUE_ONLY, QUEUE_ONLY, QUEUE_ONLY
	};

	// Expected commands in request order
	cmd_kind_t                exp_kind_q  [$];
	abort_mode_t              exp_abort_q [$];
	logic [`CU_ADDR_BITS-1:0] exp_addr_q  [$];
	line_slot_t               exp_slot_q  [$];
	cu_id_t                   exp_cu_q    [$];
	logic [`CU_LINE_BITS-1:0] exp_line_q  [$];
	cmd_tag_t                 exp_tag;
	logic [63:0]              cfg_model;
	logic [31:0]              rand_state;

	edge_write_top dut_i (
		.clock(clock), .rstn(rstn), .enable(enable), .cfg_word(cfg_word),
		.base_address(base_address), .wr_strobe(wr_strobe), .wr_index(wr_index),
		.wr_data(wr_data), .wr_cu_id(wr_cu_id), .credit_return(credit_return),
		.buf_full(buf_full), .mem_valid(mem_valid), .mem_kind(mem_kind),
		.mem_abort(mem_abort), .mem_address(mem_address), .mem_tag(mem_tag),
		.mem_slot(mem_slot), .mem_cu_id(mem_cu_id), .mem_line(mem_line)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Reference model helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state;
	endfunction

	// Codes above PREF fall back to STRICT
	function automatic abort_mode_t abort_from_cfg(input logic [2:0] code);
		abort_mode_t m;
		if (code > 3'd4)
			m = STRICT;
		else
			m = abort_mode_t'(code);
		return m;
	endfunction

	// Byte-reversed element in its word, rest zero
	function automatic logic [`CU_LINE_BITS-1:0] build_line(input line_slot_t s,
			input logic [31:0] d);
		logic [`CU_LINE_BITS-1:0] l;
		l = '0;
		l[int'(s) * 32 +: 32] = {d[7:0], d[15:8], d[23:16], d[31:24]};
		return l;
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_kind(input string name, input cmd_kind_t exp, input cmd_kind_t act);
		if (exp !== act)
			fail_run($sformatf("error: %s kind expected %s actual %s", name, exp.name(),
				act.name()));
	endtask

	task automatic check_abort(input string name, input abort_mode_t exp,
			input abort_mode_t act);
		if (exp !== act)
			fail_run($sformatf("error: %s abort expected %s actual %s", name, exp.name(),
				act.name()));
	endtask

	task automatic check_address(input string name, input logic [`CU_ADDR_BITS-1:0] exp,
			input logic [`CU_ADDR_BITS-1:0] act);
		if (exp !== act)
			fail_run($sformatf("error: %s address expected %h actual %h", name, exp, act));
	endtask

	task automatic check_tag(input string name, input cmd_tag_t exp, input cmd_tag_t act);
		if (exp !== act)
			fail_run($sformatf("error: %s tag expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_slot(input string name, input line_slot_t exp, input line_slot_t act);
		if (exp !== act)
			fail_run($sformatf("error: %s slot expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_cu_id(input string name, input cu_id_t exp, input cu_id_t act);
		if (exp !== act)
			fail_run($sformatf("error: %s cu_id expected %h actual %h", name, exp, act));
	endtask

	task automatic check_line(input string name, input logic [`CU_LINE_BITS-1:0] exp,
			input logic [`CU_LINE_BITS-1:0] act);
		if (exp !== act)
			fail_run($sformatf("error: %s line expected %h actual %h", name, exp, act));
	endtask

	//////////////////////////////////////////////////
	// Waits and drivers
	//////////////////////////////////////////////////

	task automatic wait_issue(input string name);
		int  n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < TIMEOUT) begin
			@(negedge clock);
			seen = (mem_valid === 1'b1);
			n++;
		end
		if (!seen)
			fail_run($sformatf("%s: no memory command within %0d cycles", name, TIMEOUT));
	endtask

	// Nothing may leave the DUT for a while
	task automatic expect_quiet(input string name, input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clock);
			if (mem_valid !== 1'b0)
				fail_run($sformatf("%s: memory command issued when none was due", name));
		end
	endtask

	task automatic wait_buffer_full(input string name);
		int n;
		n = 0;
		while (buf_full !== 1'b1 && n < TIMEOUT) begin
			@(negedge clock);
			if (mem_valid !== 1'b0)
				fail_run($sformatf("%s: memory command issued without a credit", name));
			n++;
		end
		if (buf_full !== 1'b1)
			fail_run($sformatf("%s: buffer never reported full", name));
	endtask

	// One-cycle credit, caller sits on a falling edge
	task automatic pulse_credit();
		credit_return = 1'b1;
		@(negedge clock);
		credit_return = 1'b0;
	endtask

	task automatic verify_issue(input string name);
		check_kind(name, exp_kind_q.pop_front(), mem_kind);
		check_abort(name, exp_abort_q.pop_front(), mem_abort);
		check_address(name, exp_addr_q.pop_front(), mem_address);
		check_tag(name, exp_tag, mem_tag);
		check_slot(name, exp_slot_q.pop_front(), mem_slot);
		check_cu_id(name, exp_cu_q.pop_front(), mem_cu_id);
		check_line(name, exp_line_q.pop_front(), mem_line);
		exp_tag = exp_tag + 8'd1;
	endtask

	task automatic run_row(input int r);
		string       name;
		logic [31:0] data;
		line_slot_t  s;
		name = $sformatf("row %0d", r);
		data = tab_rand[r] ? next_rand() : tab_data[r];
		s    = line_slot_t'(tab_index[r] % 32'd16);
		// Config cycle, latched on the next rising edge
		cfg_word = tab_cfg[r];
		if (tab_cfg[r] != '0)
			cfg_model = tab_cfg[r];
		@(negedge clock);
		cfg_word  = '0;
		wr_strobe = 1'b1;
		wr_index  = tab_index[r];
		wr_data   = data;
		wr_cu_id  = tab_cu[r];
		exp_kind_q.push_back(cfg_model[19] ? WRITE_MS : WRITE_NA);
		exp_abort_q.push_back(abort_from_cfg(cfg_model[17:15]));
		exp_addr_q.push_back(base_address + 64'(tab_index[r]) * 64'(`CU_ELEM_BYTES));
		exp_slot_q.push_back(s);
		exp_cu_q.push_back(tab_cu[r]);
		exp_line_q.push_back(build_line(s, data));
		@(negedge clock);
		wr_strobe = 1'b0;
		if (tab_mode[r] != QUEUE_ONLY) begin
			wait_issue(name);
			verify_issue(name);
			if (tab_mode[r] == RETURN_CREDIT)
				pulse_credit();
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		rstn          = 1'b0;
		enable        = 1'b0;
		cfg_word      = '0;
		base_address  = 64'h0000_0040_8000_1000;
		wr_strobe     = 1'b0;
		wr_index      = '0;
		wr_data       = '0;
		wr_cu_id      = '0;
		credit_return = 1'b0;
		rand_state    = 32'd38;
		cfg_model     = '0;
		exp_tag       = '0;
		repeat (3) @(negedge clock);
		rstn = 1'b1;
		if (mem_valid !== 1'b0 || buf_full !== 1'b0)
			fail_run("mem_valid or buf_full not low after reset");
		// Strobes while disabled go nowhere
		for (int i = 0; i < 3; i++) begin
			wr_strobe = 1'b1;
			wr_index  = next_rand();
			wr_data   = next_rand();
			wr_cu_id  = 8'h5A;
			expect_quiet("disabled strobes", 1);
			wr_strobe = 1'b0;
			expect_quiet("disabled strobes", 1);
		end
		expect_quiet("disabled strobes", 8);
		enable = 1'b1;
		@(negedge clock);
		for (int r = 0; r < NROWS; r++)
			run_row(r);
		// Credits spent, the last four rows sit in the buffer
		wait_buffer_full("credit starvation");
		expect_quiet("credit starvation", 4);
		while (exp_kind_q.size() != 0) begin
			pulse_credit();
			wait_issue("credit release");
			verify_issue("credit release");
			// One entry gone, room again
			if (buf_full !== 1'b0)
				fail_run("buffer still full after an entry was issued");
			expect_quiet("credit release", 3);
		end
		if (buf_full !== 1'b0) begin
			fail_run("buffer still full after all entries were issued");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+hdl
hdl/mem_cmd_pkg.sv
hdl/edge_data_pkg.sv
hdl/edge_data_write_control.sv
hdl/write_command_buffer.sv
hdl/write_issue_engine.sv
hdl/edge_write_top.sv
sim/edge_write_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the edge write testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f list.f --top-module edge_write_tb -Mdir obj_dir -o edge_write_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/edge_write_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0
